/* design/bus_pkg.sv */
package bus_pkg;

    // one address or one instruction
    typedef logic [31:0] word_t;

    // two instructions side by side on the fetch bus
    typedef logic [63:0] dword_t;

    // request channel
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // response channel
    // data[31:0] is the word at the 8-byte aligned address
    // data[63:32] is the word right after it
    typedef struct packed {
        logic   addr_ok;
        logic   data_ok;
        dword_t data;
    } ibus_resp_t;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    import bus_pkg::*;

    // fixed addresses of this core
    localparam word_t RESET_PC     = 32'hBFC0_0000;
    localparam word_t EXC_ENTRANCE = 32'hBFC0_0380;

    // exception raised in fetch
    typedef enum logic {
        NO_EXC   = 1'b0,
        ADDR_ERR = 1'b1
    } exc_type_e;

    // taken branch from execute
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // exception entry or eret from the commit side
    typedef struct packed {
        logic  intexc;
        logic  eret;
        word_t epc;
    } trap_t;

    // request in flight between PC and fetch-2
    typedef struct packed {
        logic      valid;
        word_t     pc;
        exc_type_e exc;
    } fetch1_data_t;

    // one decode slot
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        exc_type_e exc;
    } fetch_data_t;

    // slot 1 is older in program order, slot 0 younger
    typedef fetch_data_t [1:0] fetch_bundle_t;

endpackage

/* design/pipe_reg.sv */
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // flush wins over a held stage
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

/* design/pc_select.sv */
module pc_select (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_f,
    input  pipe_pkg::redirect_t redirect,
    input  pipe_pkg::trap_t     trap,
    output bus_pkg::word_t      pc
);

    import bus_pkg::*;
    import pipe_pkg::*;

    word_t pc_q;
    word_t pc_succ;
    word_t pc_nxt;
    word_t saved_target;
    logic  redirect_any;
    logic  saved_valid;

    // a redirect caught during a stall already owns the fetch address
    assign pc = saved_valid ? saved_target : pc_q;

    // pairs are fetched 8-byte aligned
    // an odd word only fills the older slot
    always_comb begin
        if (pc[2]) begin
            pc_succ = pc + 32'd4;
        end else begin
            pc_succ = pc + 32'd8;
        end
    end

    // exception entrance first, then eret, then branch
    always_comb begin
        redirect_any = 1'b1;
        if (trap.intexc) begin
            pc_nxt = EXC_ENTRANCE;
        end else if (trap.eret) begin
            pc_nxt = trap.epc;
        end else if (redirect.taken) begin
            pc_nxt = redirect.target;
        end else begin
            redirect_any = 1'b0;
            pc_nxt = pc_succ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
            saved_valid <= 1'b0;
        end else if (!stall_f) begin
            pc_q <= pc_nxt;
            saved_valid <= 1'b0;
        end else if (redirect_any) begin
            saved_valid <= 1'b1;
        end
    end

    // later exception overwrites a saved branch
    always_ff @(posedge clk) begin
        if (stall_f && redirect_any) begin
            saved_target <= pc_nxt;
        end
    end

endmodule

/* design/fetch_hazard.sv */
module fetch_hazard (
    input  bus_pkg::ibus_req_t  ireq,
    input  bus_pkg::ibus_resp_t iresp,
    input  logic                stall_d,
    input  pipe_pkg::redirect_t redirect,
    input  pipe_pkg::trap_t     trap,
    output logic                stall_f,
    output logic                stall_f2,
    output logic                flush_f2,
    output logic                flush_d
);

    logic i_wait;
    logic trap_flush;

    // request out but not taken by the bus yet
    assign i_wait = ireq.valid && !iresp.addr_ok;

    assign trap_flush = trap.intexc || trap.eret;

    // pc holds on bus wait or decode back-pressure
    assign stall_f = i_wait || stall_d;

    // fetch-2 only waits on decode
    assign stall_f2 = stall_d;

    // wrong path goes away in both registers
    assign flush_f2 = trap_flush || redirect.taken;
    assign flush_d  = trap_flush || redirect.taken;

endmodule

/* design/fetch_align.sv */
module fetch_align (
    input  logic                    clk,
    input  logic                    reset,
    input  pipe_pkg::fetch1_data_t  f1,
    input  bus_pkg::ibus_resp_t     iresp,
    input  logic                    stall_f2,
    input  logic                    flush_f2,
    output pipe_pkg::fetch_bundle_t bundle
);

    import bus_pkg::*;
    import pipe_pkg::*;

    dword_t hold_data;
    logic   hold_valid;
    logic   flush_q;
    dword_t live_data;
    dword_t raw;
    logic   addr_err;

    // nothing on the bus unless data_ok
    assign live_data = iresp.data_ok ? iresp.data : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            hold_valid <= stall_f2;
            flush_q <= flush_f2;
        end
    end

    // grab the response once, on the first stalled cycle
    always_ff @(posedge clk) begin
        if (stall_f2 && !hold_valid) begin
            hold_data <= live_data;
        end
    end

    assign raw = hold_valid ? hold_data : live_data;
    assign addr_err = f1.exc == ADDR_ERR;

    // older slot
    always_comb begin
        bundle[1].valid = f1.valid;
        bundle[1].pc = f1.pc;
        bundle[1].exc = f1.exc;
        if (f1.pc[2]) begin
            bundle[1].raw_instr = raw[63:32];
        end else begin
            bundle[1].raw_instr = raw[31:0];
        end
        // no fetched word behind a bad address
        if (addr_err || flush_q) begin
            bundle[1].raw_instr = '0;
        end
    end

    // younger slot is the high word of the same pair
    always_comb begin
        bundle[0].valid = f1.valid && !f1.pc[2] && !addr_err;
        bundle[0].pc = f1.pc + 32'd4;
        bundle[0].exc = NO_EXC;
        bundle[0].raw_instr = raw[63:32];
        if (addr_err || flush_q) begin
            bundle[0].raw_instr = '0;
        end
    end

endmodule

/* design/fetch_unit.sv */
module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    output bus_pkg::ibus_req_t      ireq,
    input  bus_pkg::ibus_resp_t     iresp,
    input  pipe_pkg::redirect_t     redirect,
    input  pipe_pkg::trap_t         trap,
    input  logic                    stall_d,
    output pipe_pkg::fetch_bundle_t bundle_out
);

    import bus_pkg::*;
    import pipe_pkg::*;

    word_t         pc;
    logic          stall_f;
    logic          stall_f2;
    logic          flush_f2;
    logic          flush_d;
    logic          pc_misaligned;
    fetch1_data_t  f1_next;
    fetch1_data_t  f1;
    fetch_bundle_t bundle_next;

    pc_select u_pc_select (
        .clk,
        .reset,
        .stall_f,
        .redirect,
        .trap,
        .pc
    );

    assign pc_misaligned = pc[1:0] != 2'b00;

    // bad address never reaches the bus
    // and nothing goes out in a redirect cycle
    assign ireq.valid = !pc_misaligned && !flush_f2;
    assign ireq.addr = pc;

    fetch_hazard u_fetch_hazard (
        .ireq,
        .iresp,
        .stall_d,
        .redirect,
        .trap,
        .stall_f,
        .stall_f2,
        .flush_f2,
        .flush_d
    );

    // one entry for each pc that leaves the PC stage
    always_comb begin
        f1_next.valid = !stall_f;
        f1_next.pc = pc;
        if (pc_misaligned) begin
            f1_next.exc = ADDR_ERR;
        end else begin
            f1_next.exc = NO_EXC;
        end
    end

    // F1 stage with its data one cycle behind
    pipe_reg #(
        .T(fetch1_data_t)
    ) u_f1_reg (
        .clk,
        .reset,
        .en(!stall_f2),
        .flush(flush_f2),
        .d(f1_next),
        .q(f1)
    );

    fetch_align u_fetch_align (
        .clk,
        .reset,
        .f1,
        .iresp,
        .stall_f2,
        .flush_f2,
        .bundle(bundle_next)
    );

    // F2 to decode
    pipe_reg #(
        .T(fetch_bundle_t)
    ) u_f2d_reg (
        .clk,
        .reset,
        .en(!stall_d),
        .flush(flush_d),
        .d(bundle_next),
        .q(bundle_out)
    );

endmodule

/* sim/fetch_asserts.sv */
module fetch_asserts (
    input logic                    clk,
    input logic                    reset,
    input bus_pkg::ibus_req_t      ireq,
    input pipe_pkg::redirect_t     redirect,
    input pipe_pkg::trap_t         trap,
    input logic                    stall_d,
    input pipe_pkg::fetch_bundle_t bundle_out
);

    import bus_pkg::*;
    import pipe_pkg::*;

    int unsigned fail_count = 0;
    word_t       exp_pc;
    logic        redirect_any;

    // program order successor of the older slot
    function automatic word_t next_in_order(input word_t pc);
        if (pc[2]) begin
            return pc + 32'd4;
        end
        return pc + 32'd8;
    endfunction

    assign redirect_any = trap.intexc || trap.eret || redirect.taken;

    // reference pc of the next slot that decode takes
    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc <= RESET_PC;
        end else if (trap.intexc) begin
            exp_pc <= EXC_ENTRANCE;
        end else if (trap.eret) begin
            exp_pc <= trap.epc;
        end else if (redirect.taken) begin
            exp_pc <= redirect.target;
        end else if (!stall_d && bundle_out[1].valid) begin
            exp_pc <= next_in_order(exp_pc);
        end
    end

    // fetch restarts at the reset address with an empty decode register
    assert property (@(posedge clk)
        reset |=> ireq.valid && ireq.addr == RESET_PC
                  && !bundle_out[1].valid && !bundle_out[0].valid)
    else begin
        fail_count++;
        $error("Mismatch at %0t: state after reset is wrong", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        (!stall_d && bundle_out[1].valid) |-> bundle_out[1].pc == exp_pc)
    else begin
        fail_count++;
        $error("Mismatch at %0t: slot 1 pc %h, expected %h", $time,
            bundle_out[1].pc, exp_pc);
    end

    // an aligned even word always brings its partner along
    assert property (@(posedge clk) disable iff (reset)
        (bundle_out[1].valid && bundle_out[1].pc[2:0] == 3'b000)
        |-> bundle_out[0].valid && bundle_out[0].pc == bundle_out[1].pc + 32'd4)
    else begin
        fail_count++;
        $error("Mismatch at %0t: slot 0 missing or wrong pc %h", $time,
            bundle_out[0].pc);
    end

    assert property (@(posedge clk) disable iff (reset)
        bundle_out[0].valid |-> bundle_out[1].valid && !bundle_out[1].pc[2])
    else begin
        fail_count++;
        $error("Mismatch at %0t: slot 0 valid next to an odd word", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        (bundle_out[1].valid && bundle_out[1].pc[1:0] == 2'b00)
        |-> bundle_out[1].exc == NO_EXC && bundle_out[1].raw_instr == ~bundle_out[1].pc)
    else begin
        fail_count++;
        $error("Mismatch at %0t: slot 1 instr %h at pc %h", $time,
            bundle_out[1].raw_instr, bundle_out[1].pc);
    end

    // misaligned pc carries an address error and no instruction
    assert property (@(posedge clk) disable iff (reset)
        (bundle_out[1].valid && bundle_out[1].pc[1:0] != 2'b00)
        |-> bundle_out[1].exc == ADDR_ERR && bundle_out[1].raw_instr == '0)
    else begin
        fail_count++;
        $error("Mismatch at %0t: misaligned pc %h not marked", $time,
            bundle_out[1].pc);
    end

    assert property (@(posedge clk) disable iff (reset)
        bundle_out[0].valid
        |-> bundle_out[0].exc == NO_EXC && bundle_out[0].raw_instr == ~bundle_out[0].pc)
    else begin
        fail_count++;
        $error("Mismatch at %0t: slot 0 instr %h at pc %h", $time,
            bundle_out[0].raw_instr, bundle_out[0].pc);
    end

    assert property (@(posedge clk) disable iff (reset)
        ireq.valid |-> ireq.addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("Mismatch at %0t: bus request at misaligned %h", $time, ireq.addr);
    end

    // decode back-pressure freezes the output unless a flush hits it
    assert property (@(posedge clk) disable iff (reset)
        (stall_d && !redirect_any) |=> $stable(bundle_out))
    else begin
        fail_count++;
        $error("Mismatch at %0t: bundle changed under decode stall", $time);
    end

endmodule

bind fetch_unit fetch_asserts u_asserts (
    .clk(clk),
    .reset(reset),
    .ireq(ireq),
    .redirect(redirect),
    .trap(trap),
    .stall_d(stall_d),
    .bundle_out(bundle_out)
);

/* sim/fetch_tb.sv */
module fetch_tb;

    import bus_pkg::*;
    import pipe_pkg::*;

    logic          clk;
    logic          reset;
    ibus_req_t     ireq;
    ibus_resp_t    iresp;
    redirect_t     redirect;
    trap_t         trap;
    logic          stall_d;
    fetch_bundle_t bundle_out;

    integer seed;
    int     timeout_count;
    logic   rand_stall;
    logic   hold_stall;
    logic   bus_busy;
    logic   accepted;
    word_t  accepted_addr;
    word_t  target;
    int     i;

    fetch_unit dut_i (
        .clk(clk),
        .reset(reset),
        .ireq(ireq),
        .iresp(iresp),
        .redirect(redirect),
        .trap(trap),
        .stall_d(stall_d),
        .bundle_out(bundle_out)
    );

    always #10 clk = ~clk;

    // bus model remembers what the bus took this cycle
    always @(posedge clk) begin
        accepted <= !reset && ireq.valid && iresp.addr_ok;
        accepted_addr <= ireq.addr;
    end

    // memory holds the inverse of each word address
    function automatic dword_t pair_data(input word_t addr);
        word_t base;
        base = {addr[31:3], 3'b000};
        return {~(base + 32'd4), ~base};
    endfunction

    // one falling edge, then the bus and stall inputs for the new cycle
    task automatic next_cycle();
        @(negedge clk);
        iresp.data_ok = accepted;
        iresp.data = accepted ? pair_data(accepted_addr) : '0;
        iresp.addr_ok = !bus_busy && (($random(seed) & 3) != 0);
        stall_d = hold_stall || (rand_stall && (($random(seed) & 3) == 0));
    endtask

    task automatic run_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            next_cycle();
        end
    endtask

    task automatic pulse_branch(input word_t dest);
        redirect.taken = 1'b1;
        redirect.target = dest;
        next_cycle();
        redirect = '0;
    endtask

    task automatic pulse_trap(input logic intexc, input logic eret, input word_t epc);
        trap.intexc = intexc;
        trap.eret = eret;
        trap.epc = epc;
        next_cycle();
        trap = '0;
    endtask

    task automatic wait_bundle(input string what);
        int n;
        n = 0;
        while (!bundle_out[1].valid && n < 40) begin
            next_cycle();
            n++;
        end
        if (!bundle_out[1].valid) begin
            timeout_count++;
            $display("Timeout at %0t: no valid bundle arrived for %s", $time, what);
        end
    endtask

    initial begin
        seed = 72574;
        clk = 1'b0;
        reset = 1'b1;
        redirect = '0;
        trap = '0;
        stall_d = 1'b0;
        iresp = '0;
        accepted = 1'b0;
        accepted_addr = '0;
        rand_stall = 1'b0;
        hold_stall = 1'b0;
        bus_busy = 1'b0;
        timeout_count = 0;
        run_cycles(3);
        reset = 1'b0;

        wait_bundle("first fetch after reset");
        run_cycles(20);

        // even pair target, then odd word target
        pulse_branch(32'h8000_1000);
        wait_bundle("branch to pair");
        run_cycles(10);
        pulse_branch(32'h8000_2004);
        wait_bundle("branch to odd word");
        run_cycles(10);

        // branch while the bus refuses requests
        bus_busy = 1'b1;
        run_cycles(3);
        pulse_branch(32'h8000_3000);
        run_cycles(2);
        bus_busy = 1'b0;
        wait_bundle("branch during bus wait");
        run_cycles(8);

        pulse_trap(1'b1, 1'b0, 32'h8000_0040);
        wait_bundle("exception entry");
        run_cycles(8);
        pulse_trap(1'b0, 1'b1, 32'h8000_0a08);
        wait_bundle("eret");
        run_cycles(8);
        pulse_trap(1'b1, 1'b1, 32'h8000_0b00);
        wait_bundle("exception with eret");
        run_cycles(8);

        pulse_branch(32'h8000_4002);
        wait_bundle("misaligned target");
        run_cycles(6);
        pulse_branch(32'h8000_5000);
        wait_bundle("return from misaligned stream");

        // branch saved under decode stall, then overtaken by an exception
        hold_stall = 1'b1;
        run_cycles(2);
        pulse_branch(32'h8000_6000);
        run_cycles(3);
        hold_stall = 1'b0;
        wait_bundle("saved branch");
        hold_stall = 1'b1;
        run_cycles(2);
        pulse_branch(32'h8000_7000);
        run_cycles(2);
        pulse_trap(1'b1, 1'b0, '0);
        run_cycles(2);
        hold_stall = 1'b0;
        wait_bundle("exception over saved branch");

        // random decode stalls with redirects mixed in
        rand_stall = 1'b1;
        for (i = 0; i < 12; i++) begin
            run_cycles(8 + ($random(seed) & 7));
            target = 32'h8000_0000 | (word_t'($random(seed)) & 32'h0000_fffc);
            if (i % 3 == 2) begin
                pulse_trap(1'b0, 1'b1, target);
            end else begin
                pulse_branch(target);
            end
            wait_bundle("redirect under random stall");
        end
        run_cycles(40);
        rand_stall = 1'b0;
        run_cycles(4);

        $display("assertion failures: %0d, timeouts: %0d",
            dut_i.u_asserts.fail_count, timeout_count);
        if (dut_i.u_asserts.fail_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim.f */
design/bus_pkg.sv
design/pipe_pkg.sv
design/pipe_reg.sv
design/pc_select.sv
design/fetch_hazard.sv
design/fetch_align.sv
design/fetch_unit.sv
sim/fetch_asserts.sv
sim/fetch_tb.sv
